// ==== source/wb_pkg.sv ====
package wb_pkg;

    // Bus geometry
    localparam int ADDR_W = 16;                        // Word address width
    localparam int DATA_W = 32;                        // Data bus width
    localparam int SEL_W  = DATA_W / 8;                // One select bit per byte lane

    // Memory map
    localparam logic [ADDR_W-1:0] RTY_BASE = 16'hF000; // Busy window start, runs to top

    // Result of one slave access
    typedef enum logic [1:0] {
        RES_ACK = 2'd0,                                // Access done
        RES_ERR = 2'd1,                                // Unmapped address
        RES_RTY = 2'd2                                 // Busy window, try later
    } wb_res_e;

    // Master to slave request, 55 bits
    typedef struct packed {
        logic [ADDR_W-1:0] adr;                        // Word address
        logic [DATA_W-1:0] dat;                        // Write data
        logic              we;                         // Write enable
        logic [SEL_W-1:0]  sel;                        // Byte lane select
        logic              stb;                        // Strobe
        logic              cyc;                        // Cycle, also the bus request
    } wb_req_t;

    // Slave to master response, 35 bits
    typedef struct packed {
        logic [DATA_W-1:0] dat;                        // Read data
        logic              ack;                        // Normal termination
        logic              err;                        // Error termination
        logic              rty;                        // Retry termination
    } wb_rsp_t;

endpackage

// ==== source/arbiter.sv ====
`timescale 1ns/1ps

module arbiter #(
    parameter int PORTS                 = 3,
    parameter bit ARB_ROUND_ROBIN       = 1'b1,    // 0 gives fixed priority
    parameter bit ARB_LSB_HIGH_PRIORITY = 1'b0     // 1 makes index 0 the winner
) (
    input  logic             clk_i,
    input  logic             arst_n_i,
    input  logic [PORTS-1:0] request_i,            // One request per port
    output logic [PORTS-1:0] grant_o,              // One-hot grant
    output logic             grant_valid_o         // Some port owns the bus
);

    logic [PORTS-1:0] grant_q, grant_d;            // Current owner
    logic             grant_valid_q, grant_valid_d;
    logic [PORTS-1:0] mask_q, mask_d;              // Ports still due a turn
    logic [PORTS-1:0] pick_plain;                  // Winner over all requests
    logic [PORTS-1:0] pick_masked;                 // Winner over masked requests
    logic             hold;                        // Owner still requesting

    // Highest priority requester as one-hot
    function automatic logic [PORTS-1:0] pick_one(input logic [PORTS-1:0] req);
        logic [PORTS-1:0] sel;
        sel = '0;
        if (ARB_LSB_HIGH_PRIORITY) begin
            for (int i = PORTS - 1; i >= 0; i--) begin
                if (req[i]) sel = PORTS'(1) << i;  // Lowest index written last
            end
        end else begin
            for (int i = 0; i < PORTS; i++) begin
                if (req[i]) sel = PORTS'(1) << i;  // Highest index written last
            end
        end
        return sel;
    endfunction

    // Index of a one-hot vector
    function automatic int unsigned onehot_idx(input logic [PORTS-1:0] oh);
        int unsigned idx;
        idx = 0;
        for (int i = 0; i < PORTS; i++) begin
            if (oh[i]) idx = i;
        end
        return idx;
    endfunction

    // Ports below the given one in priority order
    function automatic logic [PORTS-1:0] rr_mask(input int unsigned idx);
        logic [PORTS-1:0] m;
        for (int i = 0; i < PORTS; i++) begin
            m[i] = ARB_LSB_HIGH_PRIORITY ? (i > idx) : (i < idx);
        end
        return m;
    endfunction

    assign hold        = grant_valid_q & |(grant_q & request_i);
    assign pick_plain  = pick_one(request_i);
    assign pick_masked = pick_one(request_i & mask_q);

    always_comb begin
        grant_d       = grant_q;
        grant_valid_d = grant_valid_q;
        mask_d        = mask_q;
        if (!hold) begin                           // Free to hand out a new grant
            grant_valid_d = |request_i;
            if (ARB_ROUND_ROBIN && |pick_masked) begin
                grant_d = pick_masked;             // Next port in turn
            end else begin
                grant_d = pick_plain;              // Wrap, or fixed priority
            end
            if (ARB_ROUND_ROBIN && |request_i) begin
                mask_d = rr_mask(onehot_idx(grant_d));
            end
        end
    end

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            grant_q       <= '0;
            grant_valid_q <= 1'b0;
            mask_q        <= rr_mask(PORTS - 1);   // As if top port went last
        end else begin
            grant_q       <= grant_d;
            grant_valid_q <= grant_valid_d;
            mask_q        <= mask_d;
        end
    end

    assign grant_o       = grant_q;
    assign grant_valid_o = grant_valid_q;

endmodule

// ==== source/arbiter3_wb.sv ====
`timescale 1ns/1ps

module arbiter3_wb #(
    parameter bit ARB_ROUND_ROBIN       = 1'b1,
    parameter bit ARB_LSB_HIGH_PRIORITY = 1'b0
) (
    input  logic            clk_i,
    input  logic            arst_n_i,
    input  wb_pkg::wb_req_t m0_req_i,              // Master 0 request
    input  wb_pkg::wb_req_t m1_req_i,              // Master 1 request
    input  wb_pkg::wb_req_t m2_req_i,              // Master 2 request
    output wb_pkg::wb_rsp_t m0_rsp_o,              // Master 0 response
    output wb_pkg::wb_rsp_t m1_rsp_o,              // Master 1 response
    output wb_pkg::wb_rsp_t m2_rsp_o,              // Master 2 response
    output wb_pkg::wb_req_t s_req_o,               // Request toward the slave
    input  wb_pkg::wb_rsp_t s_rsp_i                // Slave response
);

    localparam int PORTS = 3;

    wb_pkg::wb_req_t  m_req [PORTS];               // Requests as an array
    wb_pkg::wb_rsp_t  m_rsp [PORTS];               // Responses as an array
    wb_pkg::wb_req_t  s_req;                       // Muxed request
    logic [PORTS-1:0] request;                     // Cycle lines
    logic [PORTS-1:0] grant;
    logic             grant_valid;
    logic [PORTS-1:0] m_sel;                       // Grant qualified by valid

    assign m_req[0] = m0_req_i;
    assign m_req[1] = m1_req_i;
    assign m_req[2] = m2_req_i;

    assign m_sel = grant & {PORTS{grant_valid}};

    arbiter #(
        .PORTS                 (PORTS),
        .ARB_ROUND_ROBIN       (ARB_ROUND_ROBIN),
        .ARB_LSB_HIGH_PRIORITY (ARB_LSB_HIGH_PRIORITY)
    ) arbiter_i (
        .clk_i         (clk_i),
        .arst_n_i      (arst_n_i),
        .request_i     (request),
        .grant_o       (grant),
        .grant_valid_o (grant_valid)
    );

    for (genvar g = 0; g < PORTS; g++) begin : g_port
        assign request[g]   = m_req[g].cyc;            // Cycle line is the request
        assign m_rsp[g].dat = s_rsp_i.dat;             // Data goes to everyone
        assign m_rsp[g].ack = s_rsp_i.ack & m_sel[g];  // Result only to owner
        assign m_rsp[g].err = s_rsp_i.err & m_sel[g];
        assign m_rsp[g].rty = s_rsp_i.rty & m_sel[g];
    end

    // Route the owner's request, all zero when idle
    always_comb begin
        s_req = '0;
        for (int i = 0; i < PORTS; i++) begin
            if (m_sel[i]) s_req = m_req[i];
        end
        s_req.cyc = |m_sel;                        // Held high for the whole grant
    end

    assign s_req_o  = s_req;
    assign m0_rsp_o = m_rsp[0];
    assign m1_rsp_o = m_rsp[1];
    assign m2_rsp_o = m_rsp[2];

endmodule

// ==== source/wb_ram_slave.sv ====
`timescale 1ns/1ps

module wb_ram_slave #(
    parameter int MEM_WORDS_LOG2 = 8               // Up to ADDR_W
) (
    input  logic            clk_i,
    input  logic            arst_n_i,
    input  wb_pkg::wb_req_t req_i,                 // Request from the port mux
    output wb_pkg::wb_rsp_t rsp_o                  // Registered response
);

    localparam int MEM_WORDS = 1 << MEM_WORDS_LOG2;

    logic [wb_pkg::DATA_W-1:0] mem [MEM_WORDS];    // Word storage
    logic [wb_pkg::DATA_W-1:0] dat_q;              // Read data register
    logic [MEM_WORDS_LOG2-1:0] word_idx;           // Low address bits
    logic                      in_mem;             // Address maps to storage
    logic                      busy;               // Response on the bus now
    logic                      access;             // New access this cycle
    logic                      ack_q, err_q, rty_q;
    wb_pkg::wb_res_e           res;                // Decoded result

    assign word_idx = req_i.adr[MEM_WORDS_LOG2-1:0];
    assign in_mem   = (req_i.adr >> MEM_WORDS_LOG2) == '0;
    assign busy     = ack_q | err_q | rty_q;
    assign access   = req_i.cyc & req_i.stb & ~busy;   // One response per strobe

    // Busy window wins over memory
    always_comb begin
        if (req_i.adr >= wb_pkg::RTY_BASE) begin
            res = wb_pkg::RES_RTY;
        end else if (in_mem) begin
            res = wb_pkg::RES_ACK;
        end else begin
            res = wb_pkg::RES_ERR;
        end
    end

    // Storage and read path
    always_ff @(posedge clk_i) begin
        if (access && res == wb_pkg::RES_ACK) begin
            if (req_i.we) begin
                for (int b = 0; b < wb_pkg::SEL_W; b++) begin
                    if (req_i.sel[b]) begin
                        mem[word_idx][8*b +: 8] <= req_i.dat[8*b +: 8];   // Byte lane
                    end
                end
            end else begin
                dat_q <= mem[word_idx];            // Valid alongside ack
            end
        end
    end

    // Single cycle result flags
    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            ack_q <= 1'b0;
            err_q <= 1'b0;
            rty_q <= 1'b0;
        end else begin
            ack_q <= access && res == wb_pkg::RES_ACK;
            err_q <= access && res == wb_pkg::RES_ERR;
            rty_q <= access && res == wb_pkg::RES_RTY;
        end
    end

    assign rsp_o.dat = dat_q;
    assign rsp_o.ack = ack_q;
    assign rsp_o.err = err_q;
    assign rsp_o.rty = rty_q;

endmodule

// ==== source/wb_arb_top.sv ====
`timescale 1ns/1ps

module wb_arb_top #(
    parameter bit ARB_ROUND_ROBIN       = 1'b1,    // Round-robin between masters
    parameter bit ARB_LSB_HIGH_PRIORITY = 1'b0,    // Master 2 wins ties
    parameter int MEM_WORDS_LOG2        = 8        // 256 words of RAM
) (
    input  logic            clk_i,
    input  logic            arst_n_i,
    input  wb_pkg::wb_req_t m0_req_i,
    input  wb_pkg::wb_req_t m1_req_i,
    input  wb_pkg::wb_req_t m2_req_i,
    output wb_pkg::wb_rsp_t m0_rsp_o,
    output wb_pkg::wb_rsp_t m1_rsp_o,
    output wb_pkg::wb_rsp_t m2_rsp_o
);

    wb_pkg::wb_req_t s_req;                        // Shared bus toward RAM
    wb_pkg::wb_rsp_t s_rsp;                        // RAM answer

    arbiter3_wb #(
        .ARB_ROUND_ROBIN       (ARB_ROUND_ROBIN),
        .ARB_LSB_HIGH_PRIORITY (ARB_LSB_HIGH_PRIORITY)
    ) arbiter3_wb_i (
        .clk_i    (clk_i),
        .arst_n_i (arst_n_i),
        .m0_req_i (m0_req_i),
        .m1_req_i (m1_req_i),
        .m2_req_i (m2_req_i),
        .m0_rsp_o (m0_rsp_o),
        .m1_rsp_o (m1_rsp_o),
        .m2_rsp_o (m2_rsp_o),
        .s_req_o  (s_req),
        .s_rsp_i  (s_rsp)
    );

    wb_ram_slave #(
        .MEM_WORDS_LOG2 (MEM_WORDS_LOG2)
    ) wb_ram_slave_i (
        .clk_i    (clk_i),
        .arst_n_i (arst_n_i),
        .req_i    (s_req),
        .rsp_o    (s_rsp)
    );

endmodule

// ==== tests/tb_wb_arb_top.sv ====
`timescale 1ns/1ps

module tb_wb_arb_top;

    localparam int          MAX_LINES = 64;
    localparam logic [15:0] MEM_TOP   = 16'h0100;  // 256 words with default MEM_WORDS_LOG2

    typedef struct packed {
        logic [7:0]  grp;                          // Issued together
        logic [1:0]  mst;                          // Master id
        logic [1:0]  flags;                        // Bit 0 write, bit 1 keep cyc
        logic [15:0] adr;
        logic [31:0] dat;
        logic [3:0]  sel;
        logic [1:0]  res;                          // 0 ack, 1 err, 2 rty
        logic [31:0] rdat;                         // Expected read data
    } trace_t;

    logic            clk;
    logic            arst_n;
    wb_pkg::wb_req_t m_req [3];
    wb_pkg::wb_rsp_t m_rsp [3];

    trace_t      trace_tab [MAX_LINES];
    int          n_lines;
    int          next_line;                        // First line of next group
    int          left;                             // Masters still waiting in group
    bit          lone_access;                      // Uncontested, grant not carried
    logic [31:0] mem_model [256];
    logic [2:0]  active;                           // Waiting for a response
    logic [2:0]  held;                             // Cyc kept high after last access
    int          line_of [3];
    int          wait_cnt [3];                     // Falling edges since request
    int          last_grant;                       // Round-robin model state
    int          order_q [$];                      // Predicted completion order
    int          cycle_cnt;
    int          cycle_limit = 0;

    wb_arb_top wb_arb_top_i (
        .clk_i    (clk),
        .arst_n_i (arst_n),
        .m0_req_i (m_req[0]),
        .m1_req_i (m_req[1]),
        .m2_req_i (m_req[2]),
        .m0_rsp_o (m_rsp[0]),
        .m1_rsp_o (m_rsp[1]),
        .m2_rsp_o (m_rsp[2])
    );

    task automatic check_value(input string name, input logic [31:0] exp_val,
                               input logic [31:0] act_val);
        if (exp_val !== act_val) begin
            $display("[FAIL] t=%0t %s expected %h actual %h", $time, name, exp_val, act_val);
            $display(">>> FAIL");
            $fatal(1, "mismatch on %s", name);
        end
    endtask

    // Next owner, searching downward from the last grant and wrapping
    function automatic int rr_pick(input logic [2:0] req, input int last);
        int cand;
        for (int k = 1; k <= 3; k++) begin
            cand = (last + 3 - k) % 3;
            if (req[cand]) return cand;
        end
        return -1;
    endfunction

    function automatic logic [1:0] decode_model(input logic [15:0] adr);
        if (adr >= wb_pkg::RTY_BASE) return 2'd2;  // Busy window
        if (adr < MEM_TOP) return 2'd0;
        return 2'd1;
    endfunction

    function automatic logic [1:0] flags_code(input logic [2:0] f);  // {ack, err, rty}
        case (f)
            3'b100:  return 2'd0;
            3'b010:  return 2'd1;
            3'b001:  return 2'd2;
            default: return 2'd3;                  // Several at once
        endcase
    endfunction

    task automatic load_trace;
        int          fd;
        int          cnt;
        int          grp_v, mst_v, we_v, res_v;
        logic [31:0] adr_v, dat_v, sel_v, rdat_v;
        string       line;
        fd = $fopen("tests/wb_trace.txt", "r");
        if (fd == 0) begin
            $display("ERROR: cannot open tests/wb_trace.txt");
            $display(">>> FAIL");
            $fatal(1, "trace file missing");
        end
        n_lines = 0;
        while (!$feof(fd)) begin
            line = "";
            void'($fgets(line, fd));
            if (line.len() < 2 || line.getc(0) == "#") continue;  // Blank or comment
            cnt = $sscanf(line, "%d %d %d %h %h %h %d %h",
                          grp_v, mst_v, we_v, adr_v, dat_v, sel_v, res_v, rdat_v);
            if (cnt != 8 || n_lines == MAX_LINES) begin
                $display("ERROR: trace line %0d is malformed or one too many", n_lines + 1);
                $display(">>> FAIL");
                $fatal(1, "bad trace");
            end
            trace_tab[n_lines].grp   = 8'(grp_v);
            trace_tab[n_lines].mst   = 2'(mst_v);
            trace_tab[n_lines].flags = 2'(we_v);
            trace_tab[n_lines].adr   = 16'(adr_v);
            trace_tab[n_lines].dat   = dat_v;
            trace_tab[n_lines].sel   = 4'(sel_v);
            trace_tab[n_lines].res   = 2'(res_v);
            trace_tab[n_lines].rdat  = rdat_v;
            n_lines++;
        end
        $fclose(fd);
    endtask

    // Raise every request of the next group and predict the finish order
    task automatic start_group;
        logic [7:0] grp;
        logic [2:0] req;
        int         carried;
        int         m;
        grp     = trace_tab[next_line].grp;
        req     = '0;
        carried = -1;
        while (next_line < n_lines && trace_tab[next_line].grp == grp) begin
            m            = int'(trace_tab[next_line].mst);
            line_of[m]   = next_line;
            wait_cnt[m]  = 0;
            active[m]    = 1'b1;
            req[m]       = 1'b1;
            if (held[m]) carried = m;              // Still owns the bus
            m_req[m].adr = trace_tab[next_line].adr;
            m_req[m].dat = trace_tab[next_line].dat;
            m_req[m].we  = trace_tab[next_line].flags[0];
            m_req[m].sel = trace_tab[next_line].sel;
            m_req[m].stb = 1'b1;
            m_req[m].cyc = 1'b1;
            left++;
            next_line++;
        end
        lone_access = (left == 1) && (carried < 0);
        order_q.delete();
        if (carried >= 0) begin                    // Holder goes first, no arbitration
            order_q.push_back(carried);
            req[carried] = 1'b0;
        end
        while (req != '0) begin
            m = rr_pick(req, last_grant);
            order_q.push_back(m);
            last_grant = m;
            req[m]     = 1'b0;
        end
    endtask

    task automatic finish_access(input int m, input logic [2:0] flags);
        trace_t     t;
        logic [1:0] code;
        t    = trace_tab[line_of[m]];
        code = flags_code(flags);
        check_value("completion order", order_q.pop_front(), m);
        check_value($sformatf("m%0d_rsp_o result", m), 32'(t.res), 32'(code));
        check_value("trace result vs model", 32'(decode_model(t.adr)), 32'(t.res));
        if (lone_access) check_value("ack latency", 32'd2, 32'(wait_cnt[m]));
        if (code == 2'd0 && t.flags[0]) begin
            for (int b = 0; b < 4; b++) begin
                if (t.sel[b]) mem_model[t.adr[7:0]][8*b +: 8] = t.dat[8*b +: 8];
            end
        end else if (code == 2'd0) begin
            check_value($sformatf("m%0d_rsp_o.dat", m), t.rdat, m_rsp[m].dat);
            check_value("trace data vs model", mem_model[t.adr[7:0]], t.rdat);
        end
        active[m]    = 1'b0;
        held[m]      = t.flags[1];
        m_req[m].stb = 1'b0;                       // Cyc may stay for the next group
        if (!t.flags[1]) m_req[m] = '0;
        left--;
    endtask

    // Look at every master once per falling edge
    task automatic scan_masters;
        logic [2:0] flags;
        for (int m = 0; m < 3; m++) begin
            flags = {m_rsp[m].ack, m_rsp[m].err, m_rsp[m].rty};
            if (active[m]) begin
                wait_cnt[m]++;
                if (flags != 3'b000) finish_access(m, flags);
            end else begin
                check_value($sformatf("m%0d_rsp_o flags", m), 32'd0, 32'(flags));
            end
        end
    endtask

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    initial begin
        cycle_cnt = 0;
        forever begin
            @(posedge clk);
            cycle_cnt++;
            if (cycle_limit > 0 && cycle_cnt > cycle_limit) begin
                $display("ERROR: trace did not finish within %0d cycles", cycle_limit);
                $display(">>> FAIL");
                $fatal(1, "timeout");
            end
        end
    end

    initial begin
        bit idle_edge;
        arst_n     = 1'b0;
        m_req[0]   = '0;
        m_req[1]   = '0;
        m_req[2]   = '0;
        active     = '0;
        held       = '0;
        last_grant = 2;                            // Port 2 counts as last served
        next_line  = 0;
        left       = 0;
        for (int i = 0; i < 256; i++) mem_model[i] = '0;
        load_trace();
        cycle_limit = 20 * n_lines + 50;
        repeat (3) @(negedge clk);
        arst_n = 1'b1;
        repeat (4) begin                           // Quiet bus after reset
            @(negedge clk);
            scan_masters();
        end
        while (next_line < n_lines || left != 0) begin
            @(negedge clk);
            idle_edge = (left == 0);               // Gap of one edge between groups
            scan_masters();
            if (idle_edge) start_group();
        end
        repeat (2) begin
            @(negedge clk);
            scan_masters();
        end
        $display(">>> PASS");
        $finish;
    end

endmodule

// ==== tests/wb_trace.txt ====
# grp mst we adr dat sel res rdat; adr, dat, sel and rdat in hex, the rest decimal
# we bit 0 is write, bit 1 keeps cyc into the next group; res 0 ack, 1 err, 2 rty
# Uncontested write, then read back
1 0 1 0010 deadbeef f 0 00000000
2 0 0 0010 00000000 0 0 deadbeef
# Byte lane writes
3 1 1 0020 11223344 f 0 00000000
4 1 1 0020 aabbccdd 5 0 00000000
5 2 1 0020 55667788 a 0 00000000
6 1 0 0020 00000000 0 0 55bb77dd
# Err and rty windows leave memory alone
7 2 1 0005 cafef00d f 0 00000000
8 0 1 0105 12345678 f 1 00000000
9 1 1 f005 87654321 f 2 00000000
10 2 0 0105 00000000 0 1 00000000
11 0 0 ffff 00000000 0 2 00000000
12 2 0 0005 00000000 0 0 cafef00d
# Three masters at once
13 0 1 0030 30303030 f 0 00000000
13 1 1 0031 11111111 f 0 00000000
13 2 1 0032 22222222 f 0 00000000
14 0 0 0030 00000000 0 0 30303030
14 1 0 0031 00000000 0 0 11111111
14 2 0 0032 00000000 0 0 22222222
15 0 0 0010 00000000 0 0 deadbeef
15 1 0 0105 00000000 0 1 00000000
15 2 0 f800 00000000 0 2 00000000
# Master 1 keeps cyc from group 16 into group 17
16 1 3 0040 0000abcd f 0 00000000
17 1 0 0040 00000000 0 0 0000abcd
17 0 1 0041 41414141 f 0 00000000
17 2 1 0042 42424242 f 0 00000000
18 0 0 0041 00000000 0 0 41414141
18 1 0 0040 00000000 0 0 0000abcd
18 2 0 0042 00000000 0 0 42424242

// ==== build.f ====
source/wb_pkg.sv
source/arbiter.sv
source/arbiter3_wb.sv
source/wb_ram_slave.sv
source/wb_arb_top.sv
tests/tb_wb_arb_top.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the Wishbone arbiter testbench with Verilator
set -e

cd "$(dirname "$0")"
rm -rf obj_dir
verilator --binary --timing -f build.f --top-module tb_wb_arb_top -o sim_tb
./obj_dir/sim_tb | tee sim.log
if grep -q "^>>> PASS$" sim.log; then
    echo "Simulation passed"
else
    echo "Simulation failed"
    exit 1
fi
